// ==== verilog.f ====
hdl/sd_dat_pkg.sv
hdl/dat_word_fifo.sv
hdl/dat_line_serdes.sv
hdl/dat_phys_controller.sv
hdl/dat_host_regs.sv
hdl/sd_dat_top.sv
verification/sd_dat_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= sd_dat_tb
RTL_TOP   ?= sd_dat_top
BUILD_DIR ?= obj_dir
LINTFLAGS ?= --lint-only -Wall --timing
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/sd_dat_tb.sv ====
`timescale 1ns/1ps

module sd_dat_tb
	import sd_dat_pkg::*;
();

	localparam int NUM_TESTS   = 6;
	localparam int WATCHDOG_NS = NUM_TESTS * 16 * 200 * 8; // tests x words x cycles x period

	logic        sd_clock;
	logic        reset;
	axil_req_t   host_req;
	axil_rsp_t   host_rsp;
	logic        dat_in;
	logic        dat_out;
	logic        dat_oe;
	logic [31:0] lcg_state;

	sd_dat_top #(
		.FIFO_DEPTH (16),
		.WORD_WIDTH (32)
	) sd_dat_top_inst (
		.sd_clock (sd_clock),
		.reset    (reset),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.dat_in   (dat_in),
		.dat_out  (dat_out),
		.dat_oe   (dat_oe)
	);

	always #4 sd_clock = ~sd_clock;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic xfer_status_t make_status(input logic rdy, input logic cmp,
		input logic tmo, input logic tok);
		xfer_status_t st;
		st.ready     = rdy;
		st.complete  = cmp;
		st.timed_out = tmo;
		st.token_err = tok;
		return st;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t: %s expected %h, actual %h", $time, name, exp, act));
	endtask

	task automatic check_status(input xfer_status_t exp, input xfer_status_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t: status expected %b, actual %b", $time, exp, act));
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t: %s expected %b, actual %b", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t: %s expected %b, actual %b", $time, name, exp, act));
	endtask

	task automatic check_pad_frame(input logic [33:0] exp, input logic [33:0] act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t: pad frame expected %h, actual %h",
				$time, exp, act));
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
		@(posedge sd_clock);
		host_req.awvalid <= 1'b1;
		host_req.awaddr  <= addr;
		host_req.wvalid  <= 1'b1;
		host_req.wdata   <= data;
		host_req.wstrb   <= 4'hf;
		@(negedge sd_clock);
		while (!host_rsp.awready)
			@(negedge sd_clock);
		check_flag("wready", 1'b1, host_rsp.wready);
		@(posedge sd_clock); // accepted here
		host_req.awvalid <= 1'b0;
		host_req.wvalid  <= 1'b0;
		@(negedge sd_clock);
		while (!host_rsp.bvalid)
			@(negedge sd_clock);
		check_resp("bresp", exp_resp, host_rsp.bresp);
	endtask

	task automatic axil_read(input logic [7:0] addr, input logic [1:0] exp_resp,
		output logic [31:0] data);
		@(posedge sd_clock);
		host_req.arvalid <= 1'b1;
		host_req.araddr  <= addr;
		@(negedge sd_clock);
		while (!host_rsp.arready)
			@(negedge sd_clock);
		@(posedge sd_clock);
		host_req.arvalid <= 1'b0;
		@(negedge sd_clock);
		while (!host_rsp.rvalid)
			@(negedge sd_clock);
		data = host_rsp.rdata;
		check_resp("rresp", exp_resp, host_rsp.rresp);
	endtask

	task automatic read_status(output xfer_status_t st, output logic [31:0] raw);
		axil_read(REG_STATUS, RESP_OKAY, raw);
		st = make_status(raw[0], raw[1], raw[2], raw[3]);
	endtask

	task automatic wait_complete(output xfer_status_t st);
		logic [31:0] raw;
		int          polls;
		polls = 0;
		read_status(st, raw);
		while (!st.complete && polls < 500)
		begin
			read_status(st, raw);
			polls++;
		end
		if (!st.complete)
			fail_run("transfer did not reach complete within 500 status polls");
	endtask

	// card model
	task automatic card_pause();
		repeat (4 + (next_rand() & 32'd7))
			@(posedge sd_clock);
	endtask

	task automatic card_send(input logic [31:0] payload, input int nbits);
		@(posedge sd_clock);
		dat_in <= 1'b0; // start bit
		for (int i = nbits - 1; i >= 0; i--)
		begin
			@(posedge sd_clock);
			dat_in <= payload[i];
		end
		@(posedge sd_clock);
		dat_in <= 1'b1;
	endtask

	task automatic card_capture(output logic [33:0] bits);
		@(negedge sd_clock);
		while (!dat_oe)
			@(negedge sd_clock);
		bits = '0;
		for (int i = 0; i < 34; i++)
		begin
			check_flag("dat_oe", 1'b1, dat_oe);
			bits = {bits[32:0], dat_out};
			@(negedge sd_clock);
		end
		check_flag("dat_oe", 1'b0, dat_oe); // exactly 34 cycles driven
	endtask

	task automatic card_accept_word(input logic [31:0] word, input logic [2:0] token);
		logic [33:0] bits;
		card_capture(bits);
		check_pad_frame({1'b0, word, 1'b1}, bits);
		card_pause();
		card_send({29'd0, token}, 3);
	endtask

	task automatic test_single_write();
		logic [31:0]  word;
		logic [31:0]  raw;
		xfer_status_t st;
		word = next_rand();
		axil_write(REG_CFG, 32'h0000_0001, RESP_OKAY);
		axil_write(REG_TXDATA, word, RESP_OKAY);
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		card_accept_word(word, TOKEN_ACCEPTED);
		wait_complete(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0), st);
		axil_write(REG_CTRL, 32'h4, RESP_OKAY);
		read_status(st, raw);
		check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0), st);
	endtask

	task automatic test_multi_read();
		logic [31:0]  words [5];
		logic [31:0]  data;
		logic [31:0]  raw;
		xfer_status_t st;
		for (int i = 0; i < 5; i++)
			words[i] = next_rand();
		axil_write(REG_CFG, 32'h0000_0052, RESP_OKAY); // read, multiple, 5 words
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		for (int i = 0; i < 5; i++)
		begin
			card_pause();
			card_send(words[i], 32);
		end
		wait_complete(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0), st);
		axil_write(REG_CTRL, 32'h4, RESP_OKAY);
		for (int i = 0; i < 5; i++)
		begin
			axil_read(REG_RXDATA, RESP_OKAY, data);
			check_word($sformatf("rx word %0d", i), words[i], data);
		end
		read_status(st, raw);
		check_flag("rx_empty", 1'b1, raw[5]);
	endtask

	task automatic test_write_backpressure();
		logic [31:0]  words [4];
		logic [31:0]  raw;
		xfer_status_t st;
		for (int i = 0; i < 4; i++)
			words[i] = next_rand();
		axil_write(REG_CFG, 32'h0000_0043, RESP_OKAY);
		axil_write(REG_TXDATA, words[0], RESP_OKAY);
		axil_write(REG_TXDATA, words[1], RESP_OKAY);
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		card_accept_word(words[0], TOKEN_ACCEPTED);
		card_accept_word(words[1], TOKEN_ACCEPTED);
		repeat (60)
		begin
			@(negedge sd_clock);
			check_flag("dat_oe", 1'b0, dat_oe); // stalled on empty tx fifo
		end
		read_status(st, raw);
		check_status(make_status(1'b0, 1'b0, 1'b0, 1'b0), st);
		fork
			begin
				axil_write(REG_TXDATA, words[2], RESP_OKAY);
				axil_write(REG_TXDATA, words[3], RESP_OKAY);
			end
			begin
				card_accept_word(words[2], TOKEN_ACCEPTED);
				card_accept_word(words[3], TOKEN_ACCEPTED);
			end
		join
		wait_complete(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0), st);
		axil_write(REG_CTRL, 32'h4, RESP_OKAY);
	endtask

	task automatic test_token_error();
		logic [31:0]  word;
		logic [31:0]  raw;
		xfer_status_t st;
		word = next_rand();
		axil_write(REG_CFG, 32'h0000_0001, RESP_OKAY);
		axil_write(REG_TXDATA, word, RESP_OKAY);
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		card_accept_word(word, 3'b101);
		wait_complete(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b1), st);
		axil_write(REG_CTRL, 32'h4, RESP_OKAY);
		read_status(st, raw);
		check_flag("ready", 1'b1, st.ready);
	endtask

	task automatic test_timeout();
		logic [31:0]  raw;
		xfer_status_t st;
		axil_write(REG_CFG, 32'h0000_0000, RESP_OKAY);
		axil_write(REG_TMO_LO, 32'd40, RESP_OKAY);
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		wait_complete(st); // card stays silent
		check_status(make_status(1'b0, 1'b1, 1'b1, 1'b0), st);
		axil_write(REG_CTRL, 32'h4, RESP_OKAY);
		axil_write(REG_TMO_LO, 32'd2000, RESP_OKAY);
		axil_write(REG_CTRL, 32'h1, RESP_OKAY);
		repeat (30)
			@(posedge sd_clock);
		axil_write(REG_CTRL, 32'h2, RESP_OKAY);
		read_status(st, raw);
		check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0), st);
	endtask

	task automatic test_register_errors();
		logic [31:0] data;
		axil_write(8'h20, 32'h0, RESP_SLVERR);
		axil_read(8'h20, RESP_SLVERR, data);
		axil_read(REG_RXDATA, RESP_SLVERR, data);
		check_word("rxdata when empty", 32'h0, data);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the tests finished");
	end

	initial
	begin
		sd_clock         = 1'b0;
		reset            = 1'b1;
		host_req         = '0;
		host_req.bready  = 1'b1;
		host_req.rready  = 1'b1;
		dat_in           = 1'b1; // pad idles high
		lcg_state        = 32'h2d15_82e5;
		repeat (3)
			@(posedge sd_clock);
		reset <= 1'b0;
		axil_write(REG_TMO_LO, 32'd2000, RESP_OKAY);
		axil_write(REG_TMO_HI, 32'd0, RESP_OKAY);
		test_single_write();
		test_multi_read();
		test_write_backpressure();
		test_token_error();
		test_timeout();
		test_register_errors();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== hdl/sd_dat_top.sv ====
`timescale 1ns/1ps

module sd_dat_top
	import sd_dat_pkg::*;
#(
	parameter int FIFO_DEPTH = 16,
	parameter int WORD_WIDTH = 32
)
(
	input  logic      sd_clock,
	input  logic      reset,
	input  axil_req_t host_req,
	output axil_rsp_t host_rsp,
	input  logic      dat_in,
	output logic      dat_out,
	output logic      dat_oe
);

	xfer_cfg_t             cfg;
	xfer_status_t          status;
	logic                  start;
	logic                  abort;
	logic                  ack;
	logic                  tx_push;
	logic [WORD_WIDTH-1:0] tx_wdata;
	logic                  tx_full;
	logic                  tx_pop;
	logic [WORD_WIDTH-1:0] tx_rdata;
	logic                  tx_empty;
	logic                  rx_push;
	logic [WORD_WIDTH-1:0] rx_wdata;
	logic                  rx_pop;
	logic [WORD_WIDTH-1:0] rx_rdata;
	logic                  rx_empty;
	logic                  load;
	logic [WORD_WIDTH-1:0] tx_word;
	logic                  tx_done;
	logic                  listen;
	rx_kind_e              rx_kind;
	logic                  clear;
	logic                  rx_done;
	logic [WORD_WIDTH-1:0] rx_word;
	logic [2:0]            rx_token;

	dat_host_regs regs_inst (
		.sd_clock (sd_clock),
		.reset    (reset),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.cfg      (cfg),
		.start    (start),
		.abort    (abort),
		.ack      (ack),
		.status   (status),
		.tx_push  (tx_push),
		.tx_wdata (tx_wdata),
		.tx_full  (tx_full),
		.rx_pop   (rx_pop),
		.rx_rdata (rx_rdata),
		.rx_empty (rx_empty)
	);

	dat_phys_controller ctrl_inst (
		.sd_clock (sd_clock),
		.reset    (reset),
		.cfg      (cfg),
		.start    (start),
		.abort    (abort),
		.ack      (ack),
		.status   (status),
		.tx_pop   (tx_pop),
		.tx_rdata (tx_rdata),
		.tx_empty (tx_empty),
		.rx_push  (rx_push),
		.rx_wdata (rx_wdata),
		.load     (load),
		.tx_word  (tx_word),
		.tx_done  (tx_done),
		.listen   (listen),
		.rx_kind  (rx_kind),
		.clear    (clear),
		.rx_done  (rx_done),
		.rx_word  (rx_word),
		.rx_token (rx_token)
	);

	dat_line_serdes #(
		.WORD_WIDTH (WORD_WIDTH)
	) serdes_inst (
		.sd_clock (sd_clock),
		.reset    (reset),
		.load     (load),
		.tx_word  (tx_word),
		.tx_done  (tx_done),
		.listen   (listen),
		.rx_kind  (rx_kind),
		.clear    (clear),
		.rx_done  (rx_done),
		.rx_word  (rx_word),
		.rx_token (rx_token),
		.dat_in   (dat_in),
		.dat_out  (dat_out),
		.dat_oe   (dat_oe)
	);

	dat_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.WORD_WIDTH (WORD_WIDTH)
	) tx_fifo (
		.sd_clock (sd_clock),
		.reset    (reset),
		.push     (tx_push),
		.wdata    (tx_wdata),
		.pop      (tx_pop),
		.rdata    (tx_rdata),
		.full     (tx_full),
		.empty    (tx_empty)
	);

	// word count stays below depth, full never reached
	dat_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.WORD_WIDTH (WORD_WIDTH)
	) rx_fifo (
		.sd_clock (sd_clock),
		.reset    (reset),
		.push     (rx_push),
		.wdata    (rx_wdata),
		.pop      (rx_pop),
		.rdata    (rx_rdata),
		.full     (),
		.empty    (rx_empty)
	);

endmodule

// ==== hdl/dat_host_regs.sv ====
`timescale 1ns/1ps

module dat_host_regs
	import sd_dat_pkg::*;
(
	input  logic         sd_clock,
	input  logic         reset,
	input  axil_req_t    host_req,
	output axil_rsp_t    host_rsp,
	output xfer_cfg_t    cfg,
	output logic         start,
	output logic         abort,
	output logic         ack,
	input  xfer_status_t status,
	output logic         tx_push,
	output logic [31:0]  tx_wdata,
	input  logic         tx_full,
	output logic         rx_pop,
	input  logic [31:0]  rx_rdata,
	input  logic         rx_empty
);

	logic        wr_accept;
	logic        rd_accept;
	reg_addr_e   wr_addr;
	reg_addr_e   rd_addr;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        rvalid;
	logic [1:0]  rresp;
	logic [31:0] rdata;

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] result;
		result = old_val;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				result[i*8 +: 8] = new_val[i*8 +: 8];
		end
		return result;
	endfunction

	assign wr_addr   = reg_addr_e'(host_req.awaddr);
	assign rd_addr   = reg_addr_e'(host_req.araddr);
	assign wr_accept = host_req.awvalid && host_req.wvalid && !bvalid;
	assign rd_accept = host_req.arvalid && !rvalid;

	// fifo side effects of data register access
	assign tx_push  = wr_accept && (wr_addr == REG_TXDATA) && !tx_full;
	assign tx_wdata = host_req.wdata;
	assign rx_pop   = rd_accept && (rd_addr == REG_RXDATA) && !rx_empty;

	assign host_rsp.awready = wr_accept;
	assign host_rsp.wready  = wr_accept;
	assign host_rsp.bvalid  = bvalid;
	assign host_rsp.bresp   = bresp;
	assign host_rsp.arready = rd_accept;
	assign host_rsp.rvalid  = rvalid;
	assign host_rsp.rdata   = rdata;
	assign host_rsp.rresp   = rresp;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
			start  <= 1'b0;
			abort  <= 1'b0;
			ack    <= 1'b0;
			cfg    <= '0;
		end
		else
		begin
			start <= 1'b0;
			abort <= 1'b0;
			ack   <= 1'b0;
			if (bvalid && host_req.bready)
				bvalid <= 1'b0;
			if (wr_accept)
			begin
				bvalid <= 1'b1;
				bresp  <= RESP_OKAY;
				case (wr_addr)
					REG_CTRL:
					begin
						start <= host_req.wdata[0];
						abort <= host_req.wdata[1];
						ack   <= host_req.wdata[2];
					end
					REG_CFG:
					begin
						if (host_req.wstrb[0])
						begin
							cfg.write_dir <= host_req.wdata[0];
							cfg.multiple  <= host_req.wdata[1];
							cfg.words     <= host_req.wdata[7:4];
						end
					end
					REG_TMO_LO:
						cfg.timeout[31:0] <= merge_bytes(cfg.timeout[31:0],
							host_req.wdata, host_req.wstrb);
					REG_TMO_HI:
						cfg.timeout[63:32] <= merge_bytes(cfg.timeout[63:32],
							host_req.wdata, host_req.wstrb);
					REG_TXDATA:
						if (tx_full)
							bresp <= RESP_SLVERR; // word dropped
					default:
						bresp <= RESP_SLVERR;
				endcase
			end
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
		else if (host_req.rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge sd_clock)
	begin
		if (rd_accept)
		begin
			rresp <= RESP_OKAY;
			rdata <= '0;
			case (rd_addr)
				REG_CTRL, REG_TXDATA:
					rdata <= '0; // write only
				REG_CFG:
					rdata <= {24'd0, cfg.words, 2'b00, cfg.multiple, cfg.write_dir};
				REG_TMO_LO:
					rdata <= cfg.timeout[31:0];
				REG_TMO_HI:
					rdata <= cfg.timeout[63:32];
				REG_RXDATA:
					if (rx_empty)
						rresp <= RESP_SLVERR;
					else
						rdata <= rx_rdata;
				REG_STATUS:
					rdata <= {26'd0, rx_empty, tx_full, status.token_err,
						status.timed_out, status.complete, status.ready};
				default:
					rresp <= RESP_SLVERR;
			endcase
		end
	end

	bresp_held: assert property (@(posedge sd_clock) disable iff (reset)
		bvalid && !host_req.bready |=> bvalid);

endmodule

// ==== hdl/dat_phys_controller.sv ====
`timescale 1ns/1ps

module dat_phys_controller
	import sd_dat_pkg::*;
(
	input  logic         sd_clock,
	input  logic         reset,
	input  xfer_cfg_t    cfg,
	input  logic         start,
	input  logic         abort,
	input  logic         ack,
	output xfer_status_t status,
	output logic         tx_pop,
	input  logic [31:0]  tx_rdata,
	input  logic         tx_empty,
	output logic         rx_push,
	output logic [31:0]  rx_wdata,
	output logic         load,
	output logic [31:0]  tx_word,
	input  logic         tx_done,
	output logic         listen,
	output rx_kind_e     rx_kind,
	output logic         clear,
	input  logic         rx_done,
	input  logic [31:0]  rx_word,
	input  logic [2:0]   rx_token
);

	ctrl_state_e state;
	logic [3:0]  word_cnt;
	logic [3:0]  word_target;
	logic [63:0] tmo_cnt;
	logic        tmo_hit;
	logic        timed_out;
	logic        token_err;

	assign word_target = (cfg.multiple && cfg.words != 4'd0) ? cfg.words : 4'd1;
	assign tmo_hit     = (tmo_cnt == cfg.timeout);

	assign tx_pop   = (state == ST_LOAD_WRITE) && !tx_empty;
	assign rx_push  = (state == ST_READ_FIFO_WRITE);
	assign rx_wdata = rx_word; // held by serdes until clear
	assign listen   = (state == ST_WAIT_RESPONSE) || (state == ST_READ);
	assign rx_kind  = cfg.write_dir ? RX_TOKEN : RX_WORD;
	assign clear    = (state == ST_IDLE) || (state == ST_READ_FIFO_WRITE);

	assign status.ready     = (state == ST_IDLE);
	assign status.complete  = (state == ST_WAIT_ACK);
	assign status.timed_out = timed_out;
	assign status.token_err = token_err;

	always_ff @(posedge sd_clock)
	begin
		if (tx_pop)
			tx_word <= tx_rdata;
	end

	// only counts while waiting on the card
	always_ff @(posedge sd_clock)
	begin
		if (reset || !listen)
			tmo_cnt <= '0;
		else
			tmo_cnt <= tmo_cnt + 64'd1;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			state     <= ST_RESET;
			word_cnt  <= '0;
			timed_out <= 1'b0;
			token_err <= 1'b0;
			load      <= 1'b0;
		end
		else if (abort)
		begin
			state <= ST_IDLE;
			load  <= 1'b0;
		end
		else
		begin
			load <= 1'b0;
			case (state)
				ST_RESET:
					state <= ST_IDLE;
				ST_IDLE:
					if (start)
					begin
						word_cnt  <= '0;
						timed_out <= 1'b0;
						token_err <= 1'b0;
						state     <= cfg.write_dir ? ST_LOAD_WRITE : ST_READ;
					end
				ST_LOAD_WRITE:
					if (!tx_empty)
					begin
						load  <= 1'b1;
						state <= ST_SEND;
					end
				ST_SEND:
					if (tx_done)
						state <= ST_WAIT_RESPONSE;
				ST_WAIT_RESPONSE:
					if (tmo_hit)
					begin
						timed_out <= 1'b1;
						state     <= ST_WAIT_ACK;
					end
					else if (rx_done)
					begin
						if (rx_token != TOKEN_ACCEPTED)
						begin
							token_err <= 1'b1;
							state     <= ST_WAIT_ACK;
						end
						else
						begin
							word_cnt <= word_cnt + 4'd1;
							state    <= (word_cnt + 4'd1 == word_target) ? ST_WAIT_ACK
								: ST_LOAD_WRITE;
						end
					end
				ST_READ:
					if (tmo_hit)
					begin
						timed_out <= 1'b1;
						state     <= ST_WAIT_ACK;
					end
					else if (rx_done)
					begin
						word_cnt <= word_cnt + 4'd1;
						state    <= ST_READ_FIFO_WRITE;
					end
				ST_READ_FIFO_WRITE:
					state <= (word_cnt == word_target) ? ST_WAIT_ACK : ST_READ;
				ST_WAIT_ACK:
					if (ack)
						state <= ST_IDLE;
				default:
					state <= ST_RESET;
			endcase
		end
	end

	no_push_on_load: assert property (@(posedge sd_clock) disable iff (reset)
		!(rx_push && load));

	state_legal: assert property (@(posedge sd_clock) disable iff (reset)
		state inside {ST_RESET, ST_IDLE, ST_LOAD_WRITE, ST_SEND, ST_WAIT_RESPONSE,
			ST_READ, ST_READ_FIFO_WRITE, ST_WAIT_ACK});

endmodule

// ==== hdl/dat_line_serdes.sv ====
`timescale 1ns/1ps

module dat_line_serdes
	import sd_dat_pkg::*;
#(
	parameter int WORD_WIDTH = 32
)
(
	input  logic                  sd_clock,
	input  logic                  reset,
	input  logic                  load,
	input  logic [WORD_WIDTH-1:0] tx_word,
	output logic                  tx_done,
	input  logic                  listen,
	input  rx_kind_e              rx_kind,
	input  logic                  clear,
	output logic                  rx_done,
	output logic [WORD_WIDTH-1:0] rx_word,
	output logic [2:0]            rx_token,
	input  logic                  dat_in,
	output logic                  dat_out,
	output logic                  dat_oe
);

	localparam int CNT_W = $clog2(WORD_WIDTH + 3);

	logic [WORD_WIDTH+1:0] tx_shift; // start, data, end
	logic [CNT_W-1:0]      tx_cnt;
	logic [WORD_WIDTH-1:0] rx_shift;
	logic [CNT_W-1:0]      rx_cnt;
	logic                  rx_active;

	assign dat_oe   = (tx_cnt != '0);
	assign dat_out  = dat_oe ? tx_shift[WORD_WIDTH+1] : 1'b1;
	assign rx_word  = rx_shift;
	assign rx_token = rx_shift[2:0];

	always_ff @(posedge sd_clock)
	begin
		if (load)
			tx_shift <= {1'b0, tx_word, 1'b1};
		else if (dat_oe)
			tx_shift <= {tx_shift[WORD_WIDTH:0], 1'b1};
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			tx_cnt  <= '0;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= (tx_cnt == CNT_W'(1)); // end bit on the pad now
			if (load)
				tx_cnt <= CNT_W'(WORD_WIDTH + 2);
			else if (dat_oe)
				tx_cnt <= tx_cnt - 1'b1;
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (rx_active && rx_cnt != '0)
			rx_shift <= {rx_shift[WORD_WIDTH-2:0], dat_in};
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset || clear)
		begin
			rx_active <= 1'b0;
			rx_cnt    <= '0;
			rx_done   <= 1'b0;
		end
		else if (!rx_active)
		begin
			rx_done <= 1'b0;
			if (listen && !dat_in) // start bit
			begin
				rx_active <= 1'b1;
				rx_cnt    <= (rx_kind == RX_WORD) ? CNT_W'(WORD_WIDTH) : CNT_W'(3);
			end
		end
		else if (rx_cnt != '0)
			rx_cnt <= rx_cnt - 1'b1;
		else
		begin
			rx_active <= 1'b0;
			rx_done   <= dat_in; // frame dropped without end bit
		end
	end

	no_load_while_busy: assert property (@(posedge sd_clock) disable iff (reset)
		load |-> tx_cnt == '0);

endmodule

// ==== hdl/dat_word_fifo.sv ====
`timescale 1ns/1ps

module dat_word_fifo
#(
	parameter int FIFO_DEPTH = 16,
	parameter int WORD_WIDTH = 32
)
(
	input  logic                  sd_clock,
	input  logic                  reset,
	input  logic                  push,
	input  logic [WORD_WIDTH-1:0] wdata,
	input  logic                  pop,
	output logic [WORD_WIDTH-1:0] rdata,
	output logic                  full,
	output logic                  empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  do_push;
	logic                  do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign rdata   = mem[rd_ptr]; // head word, no read latency

	always_ff @(posedge sd_clock)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	fifo_guard: assert property (@(posedge sd_clock) disable iff (reset)
		!(push && full) && !(pop && empty));

endmodule

// ==== hdl/sd_dat_pkg.sv ====
package sd_dat_pkg;

	// axi4-lite, master to slave
	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,
		REG_CFG    = 8'h04,
		REG_TMO_LO = 8'h08,
		REG_TMO_HI = 8'h0C,
		REG_TXDATA = 8'h10,
		REG_RXDATA = 8'h14,
		REG_STATUS = 8'h18
	} reg_addr_e;

	typedef struct packed {
		logic        write_dir;
		logic        multiple;
		logic [3:0]  words;
		logic [63:0] timeout;
	} xfer_cfg_t;

	typedef struct packed {
		logic ready;
		logic complete;
		logic timed_out;
		logic token_err;
	} xfer_status_t;

	typedef enum logic [3:0] {
		ST_RESET,
		ST_IDLE,
		ST_LOAD_WRITE,
		ST_SEND,
		ST_WAIT_RESPONSE,
		ST_READ,
		ST_READ_FIFO_WRITE,
		ST_WAIT_ACK
	} ctrl_state_e;

	typedef enum logic {
		RX_WORD,
		RX_TOKEN
	} rx_kind_e;

	localparam logic [2:0] TOKEN_ACCEPTED = 3'b010;

endpackage
